// ==== flist.f ====
verilog/sensorPkg.sv
verilog/sensorReadIf.sv
verilog/i2cReadMaster.sv
verilog/readScheduler.sv
verilog/sevenSegScan.sv
verilog/sensorDisplayTop.sv
testbench/i2cSensorModel.sv
testbench/sensorDisplayTb.sv

// ==== testbench/i2cSensorModel.sv ====
`timescale 1ns/100ps

module i2cSensorModel #(
	parameter logic [6:0] deviceAddr = sensorPkg::SENSOR_ADDR
) (
	input  logic scl,
	inout  wire  sda,
	input  logic [15:0] readWord,
	input  logic nackAddr
);

	localparam int IDLE = 0;
	localparam int RECV = 1;
	localparam int ACK_PEND = 2;
	localparam int ACK_SLOT = 3;
	localparam int SEND = 4;
	localparam int MASTER_ACK = 5;

	int mode = IDLE;
	logic sdaLow = 1'b0;
	int bitCnt;
	logic [7:0] shiftIn;
	logic [7:0] txByte;
	logic firstInFrame;
	logic ackThis;
	logic readDir;
	// Low data byte still to go out
	logic lowPending;
	logic masterNack;

	// ==================================================
	// Transaction log, read by the testbench
	// ==================================================
	logic [7:0] rxByte [0:7];
	int rxCount;
	// Received byte count at each START
	int startPos [0:3];
	int startCount;
	int stopCount;
	logic masterAck [0:3];
	int masterAckCount;

	assign sda = sdaLow ? 1'b0 : 1'bz;

	task automatic clearLog();
		rxCount = 0;
		startCount = 0;
		stopCount = 0;
		masterAckCount = 0;
	endtask

	// START or repeated START
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			if (startCount < 4) begin
				startPos[startCount] = rxCount;
			end
			startCount++;
			bitCnt = 0;
			firstInFrame = 1'b1;
			sdaLow = 1'b0;
			mode = RECV;
		end
	end

	// STOP
	always @(posedge sda) begin
		if (scl === 1'b1) begin
			stopCount++;
			sdaLow = 1'b0;
			mode = IDLE;
		end
	end

	// Sample on the rising clock
	always @(posedge scl) begin
		case (mode)
			RECV: begin
				shiftIn = {shiftIn[6:0], sda};
				bitCnt++;
				if (bitCnt == 8) begin
					if (rxCount < 8) begin
						rxByte[rxCount] = shiftIn;
					end
					rxCount++;
					if (firstInFrame) begin
						ackThis = !nackAddr && (shiftIn[7:1] == deviceAddr);
						readDir = shiftIn[0];
					end else begin
						ackThis = 1'b1;
						readDir = 1'b0;
					end
					firstInFrame = 1'b0;
					mode = ACK_PEND;
				end
			end
			SEND: bitCnt++;
			MASTER_ACK: begin
				masterNack = sda;
				if (masterAckCount < 4) begin
					masterAck[masterAckCount] = sda;
				end
				masterAckCount++;
			end
			default: ;
		endcase
	end

	// Drive while the clock is low
	always @(negedge scl) begin
		case (mode)
			ACK_PEND: begin
				sdaLow = ackThis;
				mode = ACK_SLOT;
			end
			ACK_SLOT: begin
				sdaLow = 1'b0;
				bitCnt = 0;
				if (!ackThis) begin
					mode = IDLE;
				end else if (readDir) begin
					// High byte first
					txByte = readWord[15:8];
					lowPending = 1'b1;
					sdaLow = !txByte[7];
					mode = SEND;
				end else begin
					mode = RECV;
				end
			end
			SEND: begin
				if (bitCnt == 8) begin
					sdaLow = 1'b0;
					mode = MASTER_ACK;
				end else begin
					sdaLow = !txByte[7 - bitCnt];
				end
			end
			MASTER_ACK: begin
				if (masterNack || !lowPending) begin
					mode = IDLE;
				end else begin
					txByte = readWord[7:0];
					lowPending = 1'b0;
					bitCnt = 0;
					sdaLow = !txByte[7];
					mode = SEND;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== testbench/sensorDisplayTb.sv ====
`timescale 1ns/100ps

module sensorDisplayTb;
	import sensorPkg::*;

	localparam int CLK_DIV = 4;
	localparam int POLL_CYCLES = 400;
	localparam int SCAN_CYCLES = 8;
	localparam int WAIT_LIMIT = 4000;

	logic I2Cclk;
	logic reset;
	wire sda;
	logic scl;
	logic [15:0] sensorWord;
	logic nackError;
	logic [6:0] cathode;
	logic [3:0] anode;

	logic [15:0] modelWord;
	logic modelNack;
	logic [15:0] heldExpect;
	logic [15:0] prevWord;
	int digitHits [0:3];
	int errorCount;
	int timeoutCount;
	int seedValue;

	pullup (sda);

	sensorDisplayTop #(
		.CLK_DIV    (CLK_DIV),
		.POLL_CYCLES(POLL_CYCLES),
		.SCAN_CYCLES(SCAN_CYCLES)
	) DUT (
		.I2Cclk    (I2Cclk),
		.reset     (reset),
		.sda       (sda),
		.scl       (scl),
		.sensorWord(sensorWord),
		.nackError (nackError),
		.cathode   (cathode),
		.anode     (anode)
	);

	i2cSensorModel sensorModel (
		.scl     (scl),
		.sda     (sda),
		.readWord(modelWord),
		.nackAddr(modelNack)
	);

	// ==================================================
	// Reference functions
	// ==================================================
	function automatic logic [7:0] expectedByte(input int idx);
		case (idx)
			0: return {SENSOR_ADDR, 1'b0};
			1: return TEMP_POINTER;
			default: return {SENSOR_ADDR, 1'b1};
		endcase
	endfunction

	// Lit segments a..g get inverted for the active-low cathodes
	function automatic logic [6:0] segPattern(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'b1111110;
			4'h1: lit = 7'b0110000;
			4'h2: lit = 7'b1101101;
			4'h3: lit = 7'b1111001;
			4'h4: lit = 7'b0110011;
			4'h5: lit = 7'b1011011;
			4'h6: lit = 7'b1011111;
			4'h7: lit = 7'b1110000;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1111011;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b0011111;
			4'hC: lit = 7'b1001110;
			4'hD: lit = 7'b0111101;
			4'hE: lit = 7'b1001111;
			default: lit = 7'b1000111;
		endcase
		return ~lit;
	endfunction

	task automatic logError(input string msg);
		errorCount++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic finishRun();
		$display("Summary: %0d errors, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// End of a read is the master's done pulse
	task automatic waitForDone(input string what);
		int cycles;
		cycles = 0;
		@(negedge I2Cclk);
		while (DUT.readBus.done !== 1'b1 && cycles < WAIT_LIMIT) begin
			cycles++;
			@(negedge I2Cclk);
		end
		if (cycles >= WAIT_LIMIT) begin
			$display("Timeout: the %s never finished within %0d cycles", what, WAIT_LIMIT);
			timeoutCount++;
		end
	endtask

	task automatic waitForAllDigits();
		int base [0:3];
		int cycles;
		cycles = 0;
		for (int i = 0; i < DIGITS; i++) begin
			base[i] = digitHits[i];
		end
		while (!(digitHits[0] > base[0] && digitHits[1] > base[1] &&
			digitHits[2] > base[2] && digitHits[3] > base[3]) && cycles < 200) begin
			cycles++;
			@(negedge I2Cclk);
		end
		if (cycles >= 200) begin
			$display("Timeout: not every display digit was scanned within 200 cycles");
			timeoutCount++;
		end
	endtask

	// Bus sequence of one good read
	task automatic checkReadLog();
		assert (sensorModel.startCount == 2 && sensorModel.startPos[0] == 0 &&
			sensorModel.startPos[1] == 2)
		else logError($sformatf("%0d STARTs seen, expected START and repeated START",
			sensorModel.startCount));
		assert (sensorModel.rxCount == 3)
		else logError($sformatf("model received %0d bytes, expected 3", sensorModel.rxCount));
		for (int i = 0; i < 3; i++) begin
			assert (sensorModel.rxByte[i] == expectedByte(i))
			else logError($sformatf("byte %0d is %h, expected %h", i,
				sensorModel.rxByte[i], expectedByte(i)));
		end
		assert (sensorModel.masterAckCount == 2 && sensorModel.masterAck[0] == 1'b0 &&
			sensorModel.masterAck[1] == 1'b1)
		else logError("master did not ACK the high byte and NACK the low byte");
		assert (sensorModel.stopCount == 1)
		else logError($sformatf("%0d STOPs seen, expected 1", sensorModel.stopCount));
	endtask

	task automatic checkGoodRead();
		checkReadLog();
		assert (sensorWord == heldExpect)
		else logError($sformatf("sensorWord %h, expected %h", sensorWord, heldExpect));
		assert (nackError == 1'b0)
		else logError("nackError set after a good read");
	endtask

	initial begin
		I2Cclk = 1'b0;
		forever begin
			#10;
			I2Cclk = ~I2Cclk;
		end
	end

	// ==================================================
	// Display checker
	// ==================================================
	// Cathodes lag the word by one register stage
	always @(negedge I2Cclk) begin
		assert ($countones(~anode) <= 1)
		else logError($sformatf("anode %b has more than one digit on", anode));
		for (int i = 0; i < DIGITS; i++) begin
			if (anode == ~(4'b0001 << i)) begin
				assert (cathode == segPattern(prevWord[4*i +: 4]))
				else logError($sformatf("digit %0d cathode %b, expected %b", i, cathode,
					segPattern(prevWord[4*i +: 4])));
				digitHits[i]++;
			end
		end
		prevWord = sensorWord;
	end

	// ==================================================
	// Stimulus and result checks
	// ==================================================
	initial begin
		reset = 1'b1;
		modelNack = 1'b0;
		errorCount = 0;
		timeoutCount = 0;
		prevWord = 16'h0000;
		for (int i = 0; i < DIGITS; i++) begin
			digitHits[i] = 0;
		end
		seedValue = 21470;
		modelWord = 16'($urandom(seedValue));

		repeat (4) @(posedge I2Cclk);
		@(negedge I2Cclk);
		assert (scl === 1'b1 && sda === 1'b1)
		else logError("bus lines not released during reset");
		assert (anode == 4'b1111 && nackError == 1'b0 && sensorWord == 16'h0000)
		else logError($sformatf("reset outputs anode %b nackError %b sensorWord %h",
			anode, nackError, sensorWord));
		sensorModel.clearLog();
		@(posedge I2Cclk);
		#2;
		reset = 1'b0;

		// First poll starts right after reset
		waitForDone("first read");
		if (timeoutCount == 0) begin
			@(negedge I2Cclk);
			heldExpect = modelWord;
			checkGoodRead();
			waitForAllDigits();
		end

		// Address NACK keeps the old word
		if (timeoutCount == 0) begin
			@(posedge I2Cclk);
			#2;
			modelNack = 1'b1;
			sensorModel.clearLog();
			waitForDone("NACKed read");
		end
		if (timeoutCount == 0) begin
			@(negedge I2Cclk);
			assert (nackError == 1'b1)
			else logError("nackError low after an address NACK");
			assert (sensorWord == heldExpect)
			else logError($sformatf("sensorWord %h changed on NACK, expected %h",
				sensorWord, heldExpect));
			assert (sensorModel.stopCount == 1 && sensorModel.rxCount == 1)
			else logError("NACKed read did not end with STOP after the address");
			@(posedge I2Cclk);
			#2;
			modelNack = 1'b0;
		end

		for (int n = 0; n < 3 && timeoutCount == 0; n++) begin
			modelWord = 16'($urandom);
			sensorModel.clearLog();
			waitForDone("repeated poll");
			if (timeoutCount == 0) begin
				@(negedge I2Cclk);
				heldExpect = modelWord;
				checkGoodRead();
				@(posedge I2Cclk);
				#2;
			end
		end
		if (timeoutCount == 0) begin
			waitForAllDigits();
		end
		finishRun();
	end

endmodule

// ==== verilog/i2cReadMaster.sv ====
`timescale 1ns/100ps

module i2cReadMaster #(
	parameter int CLK_DIV = 125,
	parameter logic [6:0] sensorAddr = sensorPkg::SENSOR_ADDR
) (
	input  logic I2Cclk,
	input  logic reset,
	input  logic sdaIn,
	output logic sdaOut,
	output logic scl,
	sensorReadIf.master bus
);
	import sensorPkg::*;

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

	masterState_t state;
	logic [DIV_W-1:0] divCnt;
	logic tick;
	// Quarter of the current bit
	logic [1:0] phase;
	logic [2:0] bitCnt;
	// 0 write address, 1 pointer, 2 read address
	logic [1:0] byteCnt;
	logic secondByte;
	logic ackBit;
	logic [7:0] shiftReg;
	logic [15:0] wordReg;
	logic sdaReg;
	logic sclReg;
	logic busyReg;
	logic doneReg;
	logic nackReg;

	// ==================================================
	// Quarter-bit tick
	// ==================================================
	always_ff @(posedge I2Cclk) begin
		if (reset || state == idle) begin
			divCnt <= '0;
		end else if (tick) begin
			divCnt <= '0;
		end else begin
			divCnt <= divCnt + 1'b1;
		end
	end

	assign tick = (divCnt == DIV_LAST);

	// ==================================================
	// Transaction FSM
	// ==================================================
	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			state      <= idle;
			phase      <= 2'd0;
			bitCnt     <= 3'd0;
			byteCnt    <= 2'd0;
			secondByte <= 1'b0;
			sdaReg     <= 1'b1;
			sclReg     <= 1'b1;
			busyReg    <= 1'b0;
			doneReg    <= 1'b0;
			nackReg    <= 1'b0;
		end else begin
			doneReg <= 1'b0;
			if (state == idle) begin
				// Bus released between reads
				sdaReg <= 1'b1;
				sclReg <= 1'b1;
				phase  <= 2'd0;
				if (bus.start) begin
					busyReg    <= 1'b1;
					nackReg    <= 1'b0;
					byteCnt    <= 2'd0;
					secondByte <= 1'b0;
					state      <= start;
				end
			end else if (tick) begin
				phase <= phase + 1'b1;
				case (state)
					// START and repeated START, sda falls while scl is high
					start, restart: begin
						case (phase)
							2'd0: sdaReg <= 1'b1;
							2'd1: sclReg <= 1'b1;
							2'd2: sdaReg <= 1'b0;
							default: begin
								sclReg <= 1'b0;
								bitCnt <= 3'd7;
								if (state == restart) begin
									byteCnt <= 2'd2;
								end
								state <= sendByte;
							end
						endcase
					end
					sendByte: begin
						case (phase)
							2'd0: sdaReg <= shiftReg[7];
							2'd1: sclReg <= 1'b1;
							2'd3: begin
								sclReg <= 1'b0;
								if (bitCnt == 3'd0) begin
									state <= getAck;
								end else begin
									bitCnt <= bitCnt - 1'b1;
								end
							end
							default: ;
						endcase
					end
					getAck: begin
						case (phase)
							2'd0: sdaReg <= 1'b1;
							2'd1: sclReg <= 1'b1;
							2'd3: begin
								sclReg <= 1'b0;
								if (ackBit) begin
									nackReg <= 1'b1;
									state   <= stop;
								end else begin
									case (byteCnt)
										2'd0: begin
											byteCnt <= 2'd1;
											bitCnt  <= 3'd7;
											state   <= sendByte;
										end
										2'd1: state <= restart;
										default: begin
											bitCnt <= 3'd7;
											state  <= readByte;
										end
									endcase
								end
							end
							default: ;
						endcase
					end
					readByte: begin
						case (phase)
							2'd0: sdaReg <= 1'b1;
							2'd1: sclReg <= 1'b1;
							2'd3: begin
								sclReg <= 1'b0;
								if (bitCnt == 3'd0) begin
									state <= sendAck;
								end else begin
									bitCnt <= bitCnt - 1'b1;
								end
							end
							default: ;
						endcase
					end
					// ACK the high byte, NACK the low byte
					sendAck: begin
						case (phase)
							2'd0: sdaReg <= secondByte;
							2'd1: sclReg <= 1'b1;
							2'd3: begin
								sclReg <= 1'b0;
								if (secondByte) begin
									state <= stop;
								end else begin
									secondByte <= 1'b1;
									bitCnt     <= 3'd7;
									state      <= readByte;
								end
							end
							default: ;
						endcase
					end
					// STOP, sda rises while scl is high
					stop: begin
						case (phase)
							2'd0: sdaReg <= 1'b0;
							2'd1: sclReg <= 1'b1;
							2'd2: sdaReg <= 1'b1;
							default: begin
								busyReg <= 1'b0;
								doneReg <= 1'b1;
								state   <= idle;
							end
						endcase
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// ==================================================
	// Shift register and received word
	// ==================================================
	always_ff @(posedge I2Cclk) begin
		if (state == idle) begin
			shiftReg <= {sensorAddr, 1'b0};
		end else if (tick) begin
			case (state)
				restart: begin
					if (phase == 2'd3) begin
						shiftReg <= {sensorAddr, 1'b1};
					end
				end
				sendByte: begin
					if (phase == 2'd3) begin
						shiftReg <= {shiftReg[6:0], 1'b1};
					end
				end
				getAck: begin
					if (phase == 2'd2) begin
						ackBit <= sdaIn;
					end else if (phase == 2'd3 && byteCnt == 2'd0) begin
						shiftReg <= TEMP_POINTER;
					end
				end
				readByte: begin
					// Sample mid-high
					if (phase == 2'd2) begin
						shiftReg <= {shiftReg[6:0], sdaIn};
					end
				end
				sendAck: begin
					if (phase == 2'd0) begin
						if (secondByte) begin
							wordReg[7:0] <= shiftReg;
						end else begin
							wordReg[15:8] <= shiftReg;
						end
					end
				end
				default: ;
			endcase
		end
	end

	assign sdaOut   = sdaReg;
	assign scl      = sclReg;
	assign bus.busy = busyReg;
	assign bus.done = doneReg;
	assign bus.nack = nackReg;
	assign bus.word = wordReg;

endmodule

// ==== verilog/readScheduler.sv ====
`timescale 1ns/100ps

module readScheduler #(
	parameter int POLL_CYCLES = 5000000
) (
	input  logic I2Cclk,
	input  logic reset,
	sensorReadIf.sched bus,
	output logic [15:0] heldWord,
	output logic nackError
);

	localparam int POLL_W = (POLL_CYCLES > 1) ? $clog2(POLL_CYCLES) : 1;
	localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(POLL_CYCLES - 1);

	logic [POLL_W-1:0] pollCnt;
	// Read issued and not yet done
	logic waiting;
	logic startReg;

	// ==================================================
	// Poll timer
	// ==================================================
	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			// Expired, so the first read goes out right after reset
			pollCnt  <= POLL_LAST;
			waiting  <= 1'b0;
			startReg <= 1'b0;
		end else begin
			startReg <= 1'b0;
			if (bus.done) begin
				pollCnt <= '0;
				waiting <= 1'b0;
			end else if (!waiting) begin
				if (pollCnt == POLL_LAST) begin
					if (!bus.busy) begin
						startReg <= 1'b1;
						waiting  <= 1'b1;
					end
				end else begin
					pollCnt <= pollCnt + 1'b1;
				end
			end
		end
	end

	assign bus.start = startReg;

	// Last good word and latest status
	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			heldWord  <= 16'h0000;
			nackError <= 1'b0;
		end else if (bus.done) begin
			nackError <= bus.nack;
			if (!bus.nack) begin
				heldWord <= bus.word;
			end
		end
	end

endmodule

// ==== verilog/sensorDisplayTop.sv ====
`timescale 1ns/100ps

module sensorDisplayTop #(
	parameter int CLK_DIV = 125,
	parameter int POLL_CYCLES = 5000000,
	parameter int SCAN_CYCLES = 50000,
	parameter logic [6:0] sensorAddr = sensorPkg::SENSOR_ADDR
) (
	input  logic I2Cclk,
	input  logic reset,
	inout  wire  sda,
	output logic scl,
	output logic [15:0] sensorWord,
	output logic nackError,
	output logic [6:0] cathode,
	output logic [3:0] anode
);

	logic sdaOut;
	logic sdaIn;

	sensorReadIf readBus ();

	readScheduler #(
		.POLL_CYCLES(POLL_CYCLES)
	) scheduler (
		.I2Cclk   (I2Cclk),
		.reset    (reset),
		.bus      (readBus.sched),
		.heldWord (sensorWord),
		.nackError(nackError)
	);

	i2cReadMaster #(
		.CLK_DIV   (CLK_DIV),
		.sensorAddr(sensorAddr)
	) master (
		.I2Cclk(I2Cclk),
		.reset (reset),
		.sdaIn (sdaIn),
		.sdaOut(sdaOut),
		.scl   (scl),
		.bus   (readBus.master)
	);

	sevenSegScan #(
		.SCAN_CYCLES(SCAN_CYCLES)
	) scanner (
		.I2Cclk (I2Cclk),
		.reset  (reset),
		.value  (sensorWord),
		.cathode(cathode),
		.anode  (anode)
	);

	// Open drain, a one releases the line to the pullup
	assign sda   = sdaOut ? 1'bz : 1'b0;
	assign sdaIn = sda;

endmodule

// ==== verilog/sensorPkg.sv ====
package sensorPkg;

	// ==================================================
	// Bus and display constants
	// ==================================================

	// 7-bit bus address of the temperature sensor
	localparam logic [6:0] SENSOR_ADDR = 7'h48;
	// Temperature register pointer
	localparam logic [7:0] TEMP_POINTER = 8'h00;
	// Digits on the multiplexed display
	localparam int DIGITS = 4;

	// ==================================================
	// I2C master states
	// ==================================================
	typedef enum logic [2:0] {
		idle,
		start,
		sendByte,
		getAck,
		readByte,
		sendAck,
		restart,
		stop
	} masterState_t;

	// Hex glyphs, active low, segment a in bit 6 down to g in bit 0
	function automatic logic [6:0] hexToSeg(input logic [3:0] nibble);
		logic [6:0] seg;
		case (nibble)
			4'h0: seg = 7'b0000001;
			4'h1: seg = 7'b1001111;
			4'h2: seg = 7'b0010010;
			4'h3: seg = 7'b0000110;
			4'h4: seg = 7'b1001100;
			4'h5: seg = 7'b0100100;
			4'h6: seg = 7'b0100000;
			4'h7: seg = 7'b0001111;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0000100;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b1100000;
			4'hC: seg = 7'b0110001;
			4'hD: seg = 7'b1000010;
			4'hE: seg = 7'b0110000;
			default: seg = 7'b0111000;
		endcase
		return seg;
	endfunction

endpackage

// ==== verilog/sensorReadIf.sv ====
`timescale 1ns/100ps

interface sensorReadIf;

	// Read request, one-cycle pulse
	logic start;

	// Master status and result
	logic busy;
	logic done;
	// Slave did not acknowledge, valid with done
	logic nack;
	// Received word, high byte first on the bus
	logic [15:0] word;

	modport sched (
		output start,
		input  busy,
		input  done,
		input  nack,
		input  word
	);

	modport master (
		input  start,
		output busy,
		output done,
		output nack,
		output word
	);

endinterface

// ==== verilog/sevenSegScan.sv ====
`timescale 1ns/100ps

module sevenSegScan #(
	parameter int SCAN_CYCLES = 50000
) (
	input  logic I2Cclk,
	input  logic reset,
	input  logic [15:0] value,
	output logic [6:0] cathode,
	output logic [3:0] anode
);
	import sensorPkg::*;

	localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
	localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_CYCLES - 1);
	localparam logic [1:0] LAST_DIGIT = 2'(DIGITS - 1);

	logic [SCAN_W-1:0] scanCnt;
	logic [1:0] digitIdx;
	logic [3:0] nibble;

	// ==================================================
	// Refresh counter and digit index
	// ==================================================
	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			scanCnt  <= '0;
			digitIdx <= 2'd0;
		end else if (scanCnt == SCAN_LAST) begin
			scanCnt <= '0;
			if (digitIdx == LAST_DIGIT) begin
				digitIdx <= 2'd0;
			end else begin
				digitIdx <= digitIdx + 1'b1;
			end
		end else begin
			scanCnt <= scanCnt + 1'b1;
		end
	end

	// Digit i shows value bits 4i+3 down to 4i
	assign nibble = value[{digitIdx, 2'b00} +: 4];

	// ==================================================
	// Registered display drive
	// ==================================================
	always_ff @(posedge I2Cclk) begin
		if (reset) begin
			// All digits dark
			anode   <= 4'b1111;
			cathode <= 7'b1111111;
		end else begin
			anode   <= ~(4'b0001 << digitIdx);
			cathode <= hexToSeg(nibble);
		end
	end

endmodule
